/* hw/kdtree_consts.svh */
// ---------------------------------------------------------------------------
// KD-tree leaf search constants
// Tree depth, node count, field widths and the Wishbone window base
// ---------------------------------------------------------------------------
`ifndef KDTREE_CONSTS_SVH
`define KDTREE_CONSTS_SVH

`define KD_DEPTH     6                // Internal levels, also search latency
`define KD_NODES     63               // Internal nodes, breadth-first order
`define KD_LEAF_W    6                // Leaf index width

`define KD_COMP_W    11               // One patch component, also median width
`define KD_NUM_COMP  5                // Components per patch
`define KD_PATCH_W   55               // Whole patch

`define KD_SEL_W     11               // Stored split index field
`define KD_NODE_W    22               // Node word, sel over median

`define KD_WB_BASE   32'h3000_0000    // Byte address of node 0
`define KD_HALF_BIT  21               // wbs_dat_i bit picking the high half

`endif

/* hw/kdtree_pkg.sv */
// ---------------------------------------------------------------------------
// KD-tree search types
// Node word as struct and as raw union, patch array, lane pipeline word
// and the node table write request
// ---------------------------------------------------------------------------
`include "kdtree_consts.svh"

package kdtree_pkg;

  // Split index on top, median in the low half
  typedef struct packed {
    logic [`KD_SEL_W-1:0]  sel;       // Component index, above 4 acts as 4
    logic [`KD_COMP_W-1:0] median;
  } kd_node_t;

  // Loaders see raw halves, levels decode the fields
  typedef union packed {
    logic [`KD_NODE_W-1:0] raw;
    kd_node_t              f;
  } kd_node_u;

  // Component 0 sits in the low bits
  typedef logic [`KD_NUM_COMP-1:0][`KD_COMP_W-1:0] kd_patch_t;

  typedef struct packed {
    logic                  valid;
    kd_patch_t             patch;
    logic [`KD_LEAF_W-1:0] path;      // Direction bits so far, newest at bit 0
  } kd_lane_t;

  typedef struct packed {
    logic                  en;
    logic [`KD_LEAF_W-1:0] addr;      // Node number 0..62
    kd_node_u              data;
  } kd_wr_req_t;

endpackage

/* hw/node_stream_loader.sv */
// ---------------------------------------------------------------------------
// Stream node loader
// Turns sender strobes into writes to consecutive nodes, wrapping at the
// last node
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module node_stream_loader import kdtree_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wb_mode_i,       // Wishbone owns loading when high
  input  logic       load_enable_i,
  input  logic       sender_valid_i,
  input  kd_node_u   sender_data_i,
  output kd_wr_req_t req_o
);

  logic [`KD_LEAF_W-1:0] addr_q;      // Next node to write
  logic                  fire;

  assign fire = sender_valid_i && load_enable_i && !wb_mode_i;

  // Request is combinational, the table takes it at the next edge
  assign req_o.en   = fire;
  assign req_o.addr = addr_q;
  assign req_o.data = sender_data_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (fire) begin
      if (addr_q == `KD_LEAF_W'(`KD_NODES - 1))
        addr_q <= '0;                 // Wrap from 62 back to the root
      else
        addr_q <= addr_q + 1'b1;
    end
  end

endmodule

/* hw/wb_node_port.sv */
// ---------------------------------------------------------------------------
// Wishbone slave for the node table
// Node writes arrive as two halves: low half latched, high half commits
// Reads return one half of a node in the low bits, registered with ack
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module wb_node_port import kdtree_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_we_i,
  input  logic [31:0]           wbs_dat_i,
  input  logic [31:0]           wbs_adr_i,
  output logic                  wbs_ack_o,
  output logic [31:0]           wbs_dat_o,
  output kd_wr_req_t            req_o,
  output logic [`KD_LEAF_W-1:0] rd_addr_o,
  input  kd_node_u              rd_data_i
);

  logic [31:0]           offset;      // Byte offset into the node window
  logic [`KD_LEAF_W-1:0] node_addr;
  logic                  start;       // First cycle of a transaction
  logic                  high_half;
  logic                  ack_q;
  logic [`KD_COMP_W-1:0] low_q;       // Low half waiting for its partner
  logic [`KD_COMP_W-1:0] rd_half;
  logic [31:0]           dat_q;

  assign offset    = wbs_adr_i - `KD_WB_BASE;
  assign node_addr = offset[`KD_LEAF_W+1:2];   // One word per node
  assign start     = wbs_stb_i && wbs_cyc_i && !ack_q;
  assign high_half = wbs_dat_i[`KD_HALF_BIT];

  // High half write commits the full node
  assign req_o.en       = start && wbs_we_i && high_half;
  assign req_o.addr     = node_addr;
  assign req_o.data.raw = {wbs_dat_i[`KD_COMP_W-1:0], low_q};

  assign rd_addr_o = node_addr;

  // Half select, same bit as on writes
  assign rd_half = high_half ? rd_data_i.raw[`KD_NODE_W-1:`KD_COMP_W]
                             : rd_data_i.raw[`KD_COMP_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= start;                 // Single cycle, start masks itself
  end

  // Low half latch
  always_ff @(posedge clk) begin
    if (start && wbs_we_i && !high_half)
      low_q <= wbs_dat_i[`KD_COMP_W-1:0];
  end

  // Read data lines up with ack
  always_ff @(posedge clk) begin
    if (start && !wbs_we_i)
      dat_q <= {{(32-`KD_COMP_W){1'b0}}, rd_half};
  end

  assign wbs_ack_o = ack_q;
  assign wbs_dat_o = dat_q;

endmodule

/* hw/node_store_arbiter.sv */
// ---------------------------------------------------------------------------
// Node table with write arbiter
// 63 node words, Wishbone wins over the stream loader on a clash
// Combinational read port plus the whole table for the level stages
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module node_store_arbiter import kdtree_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  kd_wr_req_t            wb_req_i,
  input  kd_wr_req_t            stream_req_i,
  input  logic [`KD_LEAF_W-1:0] rd_addr_i,
  output kd_node_u              rd_data_o,
  output kd_node_u              nodes_o [`KD_NODES]
);

  kd_node_u   nodes_q [`KD_NODES];
  kd_wr_req_t win;                    // Request granted this cycle

  // Fixed priority, a clashing stream write is dropped
  assign win = wb_req_i.en ? wb_req_i : stream_req_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < `KD_NODES; n++) begin
        nodes_q[n] <= '0;
      end
    end else if (win.en && (win.addr < `KD_LEAF_W'(`KD_NODES))) begin
      nodes_q[win.addr] <= win.data;  // Address 63 has no node
    end
  end

  // Out of range read gives zero
  always_comb begin
    if (rd_addr_i < `KD_LEAF_W'(`KD_NODES))
      rd_data_o = nodes_q[rd_addr_i];
    else
      rd_data_o = '0;
  end

  assign nodes_o = nodes_q;

endmodule

/* hw/kd_level.sv */
// ---------------------------------------------------------------------------
// One tree level of one search lane
// Picks the node on the current path, compares the split component
// against the median and registers the lane with the new direction bit
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module kd_level import kdtree_pkg::*; #(
  parameter int unsigned LEVEL = 0    // 0 is the root level
) (
  input  logic     clk,
  input  logic     rst_n,
  input  kd_lane_t lane_i,
  input  kd_node_u nodes_i [`KD_NODES],
  output kd_lane_t lane_o
);

  localparam int unsigned BASE = (1 << LEVEL) - 1;  // First node of this level

  logic [`KD_LEAF_W-1:0] node_idx;
  kd_node_u              node;
  logic [2:0]            comp_idx;
  logic [`KD_COMP_W-1:0] comp;
  logic                  dir;
  kd_lane_t              lane_q;

  // Path holds LEVEL bits so far, which is the position in the level
  assign node_idx = `KD_LEAF_W'(BASE) + lane_i.path;
  assign node     = nodes_i[node_idx];

  // sel above the last component clamps to it
  assign comp_idx = (node.f.sel > `KD_SEL_W'(`KD_NUM_COMP - 1))
                  ? 3'(`KD_NUM_COMP - 1) : node.f.sel[2:0];
  assign comp     = lane_i.patch[comp_idx];
  assign dir      = (comp >= node.f.median);   // Equal goes right

  always_ff @(posedge clk) begin
    if (!rst_n)
      lane_q.valid <= 1'b0;
    else
      lane_q.valid <= lane_i.valid;
  end

  always_ff @(posedge clk) begin
    lane_q.patch <= lane_i.patch;
    lane_q.path  <= {lane_i.path[`KD_LEAF_W-2:0], dir};  // Shift in from the bottom
  end

  assign lane_o = lane_q;

endmodule

/* hw/kdtree_search.sv */
// ---------------------------------------------------------------------------
// Two-lane KD-tree leaf search, top level
// Stream loader and Wishbone port share the node table through the arbiter
// Each lane descends six registered levels to a 6-bit leaf index
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module kdtree_search import kdtree_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_mode_i,
  input  logic                  load_enable_i,
  input  logic                  sender_valid_i,
  input  logic [`KD_NODE_W-1:0] sender_data_i,
  input  logic                  patch_valid_i,
  input  kd_patch_t             patch_i,
  input  logic                  patch_two_valid_i,
  input  kd_patch_t             patch_two_i,
  output logic                  leaf_valid_o,
  output logic [`KD_LEAF_W-1:0] leaf_o,
  output logic                  leaf_two_valid_o,
  output logic [`KD_LEAF_W-1:0] leaf_two_o,
  input  logic                  wbs_stb_i,
  input  logic                  wbs_cyc_i,
  input  logic                  wbs_we_i,
  input  logic [31:0]           wbs_dat_i,
  input  logic [31:0]           wbs_adr_i,
  output logic                  wbs_ack_o,
  output logic [31:0]           wbs_dat_o
);

  kd_node_u              sender_node;
  kd_wr_req_t            stream_req;
  kd_wr_req_t            wb_req;
  logic [`KD_LEAF_W-1:0] rd_addr;
  kd_node_u              rd_data;
  kd_node_u              nodes [`KD_NODES];
  kd_lane_t              lane_s [2][`KD_DEPTH+1];   // Per lane, stage inputs plus result

  assign sender_node.raw = sender_data_i;

  node_stream_loader node_stream_loader_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_mode_i      (wb_mode_i),
    .load_enable_i  (load_enable_i),
    .sender_valid_i (sender_valid_i),
    .sender_data_i  (sender_node),
    .req_o          (stream_req)
  );

  wb_node_port wb_node_port_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o),
    .req_o     (wb_req),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data)
  );

  node_store_arbiter node_store_arbiter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req_i     (wb_req),
    .stream_req_i (stream_req),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .nodes_o      (nodes)
  );

  // Lanes enter at the root with an empty path
  assign lane_s[0][0] = '{valid: patch_valid_i, patch: patch_i, path: '0};
  assign lane_s[1][0] = '{valid: patch_two_valid_i, patch: patch_two_i, path: '0};

  for (genvar ln = 0; ln < 2; ln++) begin : g_lane
    for (genvar lv = 0; lv < `KD_DEPTH; lv++) begin : g_level
      kd_level #(
        .LEVEL (lv)
      ) kd_level_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .lane_i  (lane_s[ln][lv]),
        .nodes_i (nodes),
        .lane_o  (lane_s[ln][lv+1])
      );
    end
  end

  // After the last level the path is the leaf
  assign leaf_valid_o     = lane_s[0][`KD_DEPTH].valid;
  assign leaf_o           = lane_s[0][`KD_DEPTH].path;
  assign leaf_two_valid_o = lane_s[1][`KD_DEPTH].valid;
  assign leaf_two_o       = lane_s[1][`KD_DEPTH].path;

endmodule

/* test/tb_clock_gen.sv */
// ---------------------------------------------------------------------------
// Testbench clock and reset
// Free running clock, active low reset held for a number of cycles
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o) rst_n_o = 1'b1;  // Release away from the sampling edge
  end

endmodule

/* test/tb_kdtree_search.sv */
// ---------------------------------------------------------------------------
// KD-tree leaf search testbench
// Shadow node table with reference descent, stream and Wishbone loading,
// per-lane expected leaf queues with an arrival checker, and a watchdog
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kdtree_consts.svh"

module tb_kdtree_search import kdtree_pkg::*; ();

  localparam int PERIOD_NS   = 40;
  localparam int N_SEARCH    = 200;
  localparam int N_WB        = 16;
  localparam int XFER_MAX    = 6;     // Drive, up to 4 ack waits, idle
  localparam int TEST_CYCLES = 8 + 63 + 2 * 63 * XFER_MAX + N_WB * 6 * XFER_MAX
                             + 2 * (N_SEARCH + 20) + 2 * 63 + 40;
  localparam int MARGIN      = 200;

  typedef struct packed {
    int                    due;       // Cycle the leaf must show up
    logic [`KD_LEAF_W-1:0] leaf;
  } exp_t;

  logic clk;
  logic rst_n;
  logic wb_mode_i, load_enable_i, sender_valid_i;
  logic [`KD_NODE_W-1:0] sender_data_i;
  logic patch_valid_i, patch_two_valid_i;
  kd_patch_t patch_i, patch_two_i;
  logic leaf_valid_o, leaf_two_valid_o;
  logic [`KD_LEAF_W-1:0] leaf_o, leaf_two_o;
  logic wbs_stb_i, wbs_cyc_i, wbs_we_i, wbs_ack_o;
  logic [31:0] wbs_dat_i, wbs_adr_i, wbs_dat_o;

  kd_node_u shadow [`KD_NODES];       // What the table should hold
  exp_t     exp_one_q [$];
  exp_t     exp_two_q [$];
  exp_t     e_one, e_two;
  integer   seed = 32'hcf71e28c;
  int       cycle = 0;
  int       stream_addr = 0;          // Mirrors the loader counter
  string    test_name = "reset";

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(8)) tb_clock_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  kdtree_search kdtree_search_i (.*);

  always @(posedge clk) cycle <= cycle + 1;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_leaf(input string what, input logic [`KD_LEAF_W-1:0] exp,
                            input logic [`KD_LEAF_W-1:0] act);
    if (exp !== act)
      report_failure($sformatf("Fail %s %s expected %0d actual %0d",
                               test_name, what, exp, act));
  endtask

  task automatic check_node(input string what, input kd_node_u exp, input kd_node_u act);
    if (exp !== act)
      report_failure($sformatf("Fail %s %s expected %h actual %h",
                               test_name, what, exp.raw, act.raw));
  endtask

  // Descent by the decision rule over the shadow table
  function automatic logic [`KD_LEAF_W-1:0] ref_leaf(input kd_patch_t p);
    logic [`KD_LEAF_W-1:0] path;
    kd_node_u              nd;
    int                    comp;
    path = '0;
    for (int lv = 0; lv < `KD_DEPTH; lv++) begin
      nd   = shadow[(1 << lv) - 1 + path];
      comp = (nd.f.sel > 4) ? 4 : nd.f.sel;       // Large sel means component 4
      path = {path[`KD_LEAF_W-2:0], p[comp] >= nd.f.median};
    end
    return path;
  endfunction

  function automatic kd_node_u rand_node();
    kd_node_u n;
    n.f.sel    = 11'($unsigned($random(seed)) % 8);  // Some above 4 on purpose
    n.f.median = 11'($random(seed));
    return n;
  endfunction

  function automatic kd_patch_t rand_patch();
    kd_patch_t p;
    for (int c = 0; c < `KD_NUM_COMP; c++) p[c] = 11'($random(seed));
    return p;
  endfunction

  task automatic check_arrival(input string lane, input exp_t e,
                               input logic [`KD_LEAF_W-1:0] leaf);
    check_leaf(lane, e.leaf, leaf);
    if (cycle != e.due)
      report_failure($sformatf("Fail %s %s arrival cycle expected %0d actual %0d",
                               test_name, lane, e.due, cycle));
  endtask

  // Compares every leaf that comes out against its lane queue
  always @(negedge clk) begin
    if (rst_n && leaf_valid_o) begin
      if (exp_one_q.size() == 0) begin
        report_failure("Lane one gave a valid leaf while no patch was expected");
      end else begin
        e_one = exp_one_q.pop_front();
        check_arrival("lane one", e_one, leaf_o);
      end
    end
    if (rst_n && leaf_two_valid_o) begin
      if (exp_two_q.size() == 0) begin
        report_failure("Lane two gave a valid leaf while no patch was expected");
      end else begin
        e_two = exp_two_q.pop_front();
        check_arrival("lane two", e_two, leaf_two_o);
      end
    end
  end

  initial begin
    #((TEST_CYCLES + MARGIN) * PERIOD_NS);
    report_failure("Watchdog expired before all tests finished");
  end

  // One Wishbone transfer, hi picks the node half
  task automatic wb_xfer(input logic we, input int node, input logic hi,
                         input logic [10:0] data, output logic [31:0] rdata);
    int waited;
    @(negedge clk);
    if (wbs_ack_o)
      report_failure("Wishbone ack stayed high longer than one cycle");
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = `KD_WB_BASE + 32'(node) * 4;
    wbs_dat_i = {10'b0, hi, 10'b0, data};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wbs_ack_o && waited < 4);
    if (!wbs_ack_o) begin
      report_failure("Wishbone ack did not come within 4 cycles");
    end else begin
      rdata     = wbs_dat_o;
      wbs_stb_i = 1'b0;
      wbs_cyc_i = 1'b0;
    end
  endtask

  task automatic read_node(input int node, output kd_node_u n);
    logic [31:0] lo, hi;
    wb_xfer(1'b0, node, 1'b0, '0, lo);
    wb_xfer(1'b0, node, 1'b1, '0, hi);
    if ({lo[31:11], hi[31:11]} !== '0)
      report_failure($sformatf("Fail %s node %0d read upper bits expected 0 actual %h %h",
                               test_name, node, lo[31:11], hi[31:11]));
    n.raw = {hi[10:0], lo[10:0]};
  endtask

  task automatic stream_node(input kd_node_u n);
    @(negedge clk);
    sender_valid_i = 1'b1;
    sender_data_i  = n.raw;
    shadow[stream_addr] = n;
    stream_addr = (stream_addr == `KD_NODES - 1) ? 0 : stream_addr + 1;
  endtask

  task automatic put_patch(input bit two, input logic vld, input kd_patch_t p,
                           input logic [`KD_LEAF_W-1:0] exp);
    if (two) begin
      patch_two_valid_i = vld;
      patch_two_i       = p;
      if (vld) exp_two_q.push_back('{due: cycle + `KD_DEPTH, leaf: exp});
    end else begin
      patch_valid_i = vld;
      patch_i       = p;
      if (vld) exp_one_q.push_back('{due: cycle + `KD_DEPTH, leaf: exp});
    end
  endtask

  task automatic drive_patches(input int n, input bit both, input bit gaps);
    kd_patch_t p1, p2;
    logic      v1, v2;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      p1 = rand_patch();
      p2 = rand_patch();
      v1 = gaps ? 1'($random(seed)) : 1'b1;
      v2 = both && (gaps ? 1'($random(seed)) : 1'b1);
      put_patch(1'b0, v1, p1, ref_leaf(p1));
      put_patch(1'b1, v2, p2, ref_leaf(p2));
    end
    @(negedge clk);
    patch_valid_i     = 1'b0;
    patch_two_valid_i = 1'b0;
  endtask

  // Waits until every expected leaf has come out of both lanes
  task automatic drain_lanes();
    int waited;
    waited = 0;
    while ((exp_one_q.size() != 0 || exp_two_q.size() != 0) && waited < `KD_DEPTH + 4) begin
      @(negedge clk);
      waited++;
    end
    if (exp_one_q.size() != 0 || exp_two_q.size() != 0)
      report_failure("Some expected leaves never came out of the lanes");
  endtask

  initial begin
    kd_node_u    n, rd;
    kd_patch_t   p;
    logic [31:0] dummy;
    int          a;
    {wb_mode_i, load_enable_i, sender_valid_i, sender_data_i} = '0;
    {patch_valid_i, patch_two_valid_i, patch_i, patch_two_i} = '0;
    {wbs_stb_i, wbs_cyc_i, wbs_we_i, wbs_dat_i, wbs_adr_i}   = '0;
    for (int i = 0; i < `KD_NODES; i++) shadow[i] = '0;
    @(posedge rst_n);
    @(negedge clk);
    if (leaf_valid_o || leaf_two_valid_o || wbs_ack_o)
      report_failure("Valid or ack outputs were high right after reset");

    test_name = "stream_load";
    load_enable_i = 1'b1;
    for (int i = 0; i < `KD_NODES; i++) stream_node(rand_node());
    @(negedge clk) sender_valid_i = 1'b0;
    for (int i = 0; i < `KD_NODES; i++) begin
      read_node(i, rd);
      check_node($sformatf("node %0d", i), shadow[i], rd);
    end

    test_name = "wb_write";
    wb_mode_i = 1'b1;
    for (int i = 0; i < N_WB; i++) begin
      a = $unsigned($random(seed)) % `KD_NODES;
      n = rand_node();
      wb_xfer(1'b1, a, 1'b0, n.raw[10:0], dummy);      // Low half only, no commit
      read_node(a, rd);
      check_node($sformatf("node %0d after low half", a), shadow[a], rd);
      wb_xfer(1'b1, a, 1'b1, n.raw[21:11], dummy);
      shadow[a] = n;
      read_node(a, rd);
      check_node($sformatf("node %0d", a), shadow[a], rd);
    end

    test_name = "lane_one";
    drive_patches(N_SEARCH, 1'b0, 1'b0);
    drain_lanes();
    test_name = "both_lanes";
    drive_patches(N_SEARCH, 1'b1, 1'b1);
    drain_lanes();

    // Medians all 1024, odd nodes get sel far above 4
    test_name = "directed";
    wb_mode_i = 1'b0;
    for (int i = 0; i < `KD_NODES; i++) begin
      n.f.sel    = (i % 2) ? 11'(9 + i) : 11'(i % 5);
      n.f.median = 11'd1024;
      stream_node(n);
    end
    @(negedge clk) sender_valid_i = 1'b0;
    @(negedge clk);
    put_patch(1'b0, 1'b1, {`KD_NUM_COMP{11'd1024}}, 6'h3f);   // Equal always goes right
    p = '0;
    p[4] = 11'd1024;
    put_patch(1'b1, 1'b1, p, ref_leaf(p));
    @(negedge clk);
    {patch_valid_i, patch_two_valid_i} = '0;
    drain_lanes();

    // Every sel maxed out, only component 4 decides
    n.f.sel    = 11'h7ff;
    n.f.median = 11'd500;
    for (int i = 0; i < `KD_NODES; i++) stream_node(n);
    @(negedge clk) sender_valid_i = 1'b0;
    @(negedge clk);
    put_patch(1'b0, 1'b1, {11'd600, {4{11'd0}}}, 6'h3f);
    put_patch(1'b1, 1'b1, {11'd400, {4{11'h7ff}}}, 6'h00);
    @(negedge clk);
    put_patch(1'b0, 1'b1, {11'd500, {4{11'd0}}}, 6'h3f);
    put_patch(1'b1, 1'b0, '0, '0);
    @(negedge clk) patch_valid_i = 1'b0;
    drain_lanes();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+hw
hw/kdtree_pkg.sv
hw/node_stream_loader.sv
hw/wb_node_port.sv
hw/node_store_arbiter.sv
hw/kd_level.sv
hw/kdtree_search.sv
test/tb_clock_gen.sv
test/tb_kdtree_search.sv

/* Bender.yml */
package:
  name: kdtree_search

export_include_dirs:
  - hw

sources:
  - files:
      - hw/kdtree_pkg.sv
      - hw/node_stream_loader.sv
      - hw/wb_node_port.sv
      - hw/node_store_arbiter.sv
      - hw/kd_level.sv
      - hw/kdtree_search.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_kdtree_search.sv
